// ==== src.f ====
common/soc_pkg.sv
source/bus_decode.sv
source/sys_regs.sv
source/boot_ram.sv
uart/uart_ctrl.sv
uart/uart_tx.sv
source/soc_periph.sv
tests/periph_checker.sv
tests/tb_soc_periph.sv

// ==== Makefile ====
# Verilator build and run for the peripheral subsystem testbench

SIM := obj_dir/Vtb_soc_periph
SRCS := $(wildcard common/*.sv source/*.sv uart/*.sv tests/*.sv)

.PHONY: all run clean

all: run

$(SIM): src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_soc_periph

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_soc_periph.sv ====
// testbench for the peripheral subsystem, table driven bus host with watchdog
`timescale 1ns/100ps

module tb_soc_periph;

  localparam int NUM_UARTS = 2;
  localparam logic [15:0] TEST_DIV = 16'd4;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_IDLE
  } op_t;

  typedef struct {
    op_t             op;
    soc_pkg::addr_t  addr;
    soc_pkg::word_t  wdata;
    soc_pkg::wstrb_t wstrb;
    soc_pkg::word_t  exp_rdata;
    logic            exp_fault;
    logic            chk_rdata;
    int              uart;
    int              cycles;
  } step_t;

  logic                      clk;
  logic                      resetn;
  logic                      mem_valid;
  soc_pkg::addr_t            mem_addr;
  soc_pkg::word_t            mem_wdata;
  soc_pkg::wstrb_t           mem_wstrb;
  soc_pkg::word_t            mem_rdata;
  logic                      mem_ready;
  logic                      access_fault;
  logic                      core_resetn;
  logic [NUM_UARTS-1:0]      uart_tx;

  // expectations for the checker
  int                        test_id;
  soc_pkg::word_t            exp_rdata;
  logic                      exp_fault;
  logic                      chk_rdata;
  logic [15:0]               div_prog;
  logic [NUM_UARTS-1:0][7:0] exp_byte;

  int          check_count;
  int          frame_count;
  int          reboot_count;
  int          checker_errors;
  int          host_errors;
  int          accesses;
  int          frames_sent;
  int          watchdog_cycles;
  logic        steps_ready;
  logic [31:0] rng_state;
  step_t       steps [$];

  always #2 clk = ~clk;

  soc_periph #(
    .NUM_UARTS(NUM_UARTS)
  ) soc_periph_i (
    .clk           (clk),
    .resetn        (resetn),
    .mem_valid_i   (mem_valid),
    .mem_addr_i    (mem_addr),
    .mem_wdata_i   (mem_wdata),
    .mem_wstrb_i   (mem_wstrb),
    .mem_rdata_o   (mem_rdata),
    .mem_ready_o   (mem_ready),
    .access_fault_o(access_fault),
    .core_resetn_o (core_resetn),
    .uart_tx_o     (uart_tx)
  );

  periph_checker #(
    .NUM_UARTS(NUM_UARTS)
  ) periph_checker_i (
    .clk           (clk),
    .resetn        (resetn),
    .mem_valid_i   (mem_valid),
    .mem_ready_i   (mem_ready),
    .mem_rdata_i   (mem_rdata),
    .access_fault_i(access_fault),
    .core_resetn_i (core_resetn),
    .uart_tx_i     (uart_tx),
    .test_id_i     (test_id),
    .exp_rdata_i   (exp_rdata),
    .exp_fault_i   (exp_fault),
    .chk_rdata_i   (chk_rdata),
    .div_i         (div_prog),
    .exp_byte_i    (exp_byte),
    .check_count_o (check_count),
    .frame_count_o (frame_count),
    .reboot_count_o(reboot_count),
    .error_count_o (checker_errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // strobed bytes of the new word replace the old ones
  function automatic soc_pkg::word_t merge_bytes(input soc_pkg::word_t old_w,
                                                 input soc_pkg::word_t new_w,
                                                 input soc_pkg::wstrb_t strb);
    soc_pkg::word_t w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////
  task automatic add_write(input soc_pkg::addr_t a, input soc_pkg::word_t d,
                           input soc_pkg::wstrb_t s, input logic flt, input int u);
    steps.push_back('{OP_WRITE, a, d, s, 32'h0, flt, 1'b0, u, 0});
    accesses++;
    if (u >= 0) frames_sent++;
  endtask

  task automatic expect_read(input soc_pkg::addr_t a, input soc_pkg::word_t exp,
                             input logic flt);
    steps.push_back('{OP_READ, a, 32'h0, 4'h0, exp, flt, 1'b1, -1, 0});
    accesses++;
  endtask

  task automatic insert_idle(input int n);
    steps.push_back('{OP_IDLE, 32'h0, 32'h0, 4'h0, 32'h0, 1'b0, 1'b0, -1, n});
  endtask

  task automatic build_steps();
    soc_pkg::addr_t  a;
    soc_pkg::addr_t  tx_addr;
    soc_pkg::word_t  ram_model [8];
    soc_pkg::wstrb_t partial [8];
    partial = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b0101, 4'b1010};
    // boot ram, full writes then partial overwrites then reads
    for (int i = 0; i < 8; i++) begin
      a = soc_pkg::addr_t'(i) * 32'h84;
      rng_state = xorshift32(rng_state);
      ram_model[i] = rng_state;
      add_write(a, rng_state, 4'hf, 1'b0, -1);
    end
    for (int i = 0; i < 8; i++) begin
      a = soc_pkg::addr_t'(i) * 32'h84;
      rng_state = xorshift32(rng_state);
      ram_model[i] = merge_bytes(ram_model[i], rng_state, partial[i]);
      add_write(a, rng_state, partial[i], 1'b0, -1);
    end
    for (int i = 0; i < 8; i++) begin
      expect_read(soc_pkg::addr_t'(i) * 32'h84, ram_model[i], 1'b0);
    end
    // system registers
    add_write(soc_pkg::DIV_ADDR, 32'h0000_1234, 4'hf, 1'b0, -1);
    expect_read(soc_pkg::DIV_ADDR, 32'h0000_1234, 1'b0);
    expect_read(soc_pkg::CPU_FREQ_ADDR, 32'd250_000_000, 1'b0);
    expect_read(soc_pkg::MEM_SIZE_ADDR, 32'd1024, 1'b0);
    // uarts, status reads busy during the frame and empty after it
    add_write(soc_pkg::DIV_ADDR, {16'h0, TEST_DIV}, 4'hf, 1'b0, -1);
    for (int u = 0; u < NUM_UARTS; u++) begin
      tx_addr = 32'h1000_0000 + soc_pkg::addr_t'(u) * 32'h1000;
      add_write(tx_addr, 32'h0000_00a5 + soc_pkg::word_t'(u) * 32'h5a, 4'h1, 1'b0, u);
      expect_read(tx_addr + 32'h5, 32'h0, 1'b0);
    end
    insert_idle(12 * int'(TEST_DIV) + 8);
    for (int u = 0; u < NUM_UARTS; u++) begin
      expect_read(32'h1000_0005 + soc_pkg::addr_t'(u) * 32'h1000, 32'h0000_6000, 1'b0);
    end
    // unclaimed io reads zero, outside every region faults
    expect_read(32'h1000_0100, 32'h0, 1'b0);
    expect_read(32'h4000_0000, 32'h0, 1'b1);
    add_write(32'h4000_0000, 32'hdead_beef, 4'hf, 1'b1, -1);
    // reboot clears the divider
    add_write(soc_pkg::REBOOT_ADDR, 32'h0000_7777, 4'h3, 1'b0, -1);
    insert_idle(16 + 4);
    expect_read(soc_pkg::DIV_ADDR, 32'h0, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // bus host
  ////////////////////////////////////////////////////////////
  task automatic run_access(input int idx, input step_t st);
    int waited;
    test_id   = idx;
    exp_rdata = st.exp_rdata;
    exp_fault = st.exp_fault;
    chk_rdata = st.chk_rdata;
    mem_addr  = st.addr;
    mem_wdata = st.wdata;
    mem_wstrb = st.wstrb;
    mem_valid = 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      #0.5;
      waited++;
    end while (!mem_ready && waited < 8);
    if (!mem_ready) begin
      $display("step %0d got no ready from address %h", idx, st.addr);
      host_errors++;
    end
    @(posedge clk);
    #0.5;
    mem_valid = 1'b0;
  endtask

  initial begin : main_seq
    step_t st;
    int    waited;
    clk = 1'b0;
    resetn = 1'b0;
    mem_valid = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    test_id = 0;
    exp_rdata = '0;
    exp_fault = 1'b0;
    chk_rdata = 1'b0;
    div_prog = '0;
    exp_byte = '0;
    host_errors = 0;
    accesses = 0;
    frames_sent = 0;
    rng_state = 32'h7e6e;
    build_steps();
    watchdog_cycles = 16 + soc_pkg::RESET_HOLD + 200 + frames_sent * 10 * int'(TEST_DIV);
    foreach (steps[i]) watchdog_cycles += (steps[i].op == OP_IDLE) ? steps[i].cycles : 2;
    steps_ready = 1'b1;

    repeat (16) @(posedge clk);
    #0.5;
    resetn = 1'b1;
    waited = 0;
    while (core_resetn !== 1'b1 && waited < 8) begin
      @(posedge clk);
      #0.5;
      waited++;
    end
    if (core_resetn !== 1'b1) begin
      $display("core reset was not released after the board reset");
      host_errors++;
    end

    for (int i = 0; i < steps.size(); i++) begin
      st = steps[i];
      if (st.op == OP_IDLE) begin
        repeat (st.cycles) @(posedge clk);
        #0.5;
      end else begin
        if (st.op == OP_WRITE && st.addr == soc_pkg::DIV_ADDR) div_prog = st.wdata[15:0];
        if (st.uart >= 0) exp_byte[st.uart] = st.wdata[7:0];
        run_access(i, st);
        if (st.op == OP_WRITE && st.addr == soc_pkg::REBOOT_ADDR) div_prog = '0;
      end
    end

    repeat (4) @(posedge clk);
    #0.5;
    if (check_count != accesses) begin
      $display("%0d accesses issued but %0d replies checked", accesses, check_count);
      host_errors++;
    end
    if (frame_count != frames_sent) begin
      $display("%0d serial frames expected but %0d decoded", frames_sent, frame_count);
      host_errors++;
    end
    if (reboot_count != 1) begin
      $display("one core reset pulse expected but %0d seen", reboot_count);
      host_errors++;
    end
    $display("%0d bus checks, %0d frames, %0d reboot pulses, %0d errors",
             check_count, frame_count, reboot_count, checker_errors + host_errors);
    if (checker_errors + host_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // limit from the table length plus the serial frame times
  initial begin : watchdog
    wait (steps_ready === 1'b1);
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== tests/periph_checker.sv ====
// bus and serial line monitor, compares replies, frames and core reset pulses
`timescale 1ns/100ps

module periph_checker #(
  parameter int NUM_UARTS = 2
) (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      mem_valid_i,
  input  logic                      mem_ready_i,
  input  soc_pkg::word_t            mem_rdata_i,
  input  logic                      access_fault_i,
  input  logic                      core_resetn_i,
  input  logic [NUM_UARTS-1:0]      uart_tx_i,
  input  int                        test_id_i,
  input  soc_pkg::word_t            exp_rdata_i,
  input  logic                      exp_fault_i,
  input  logic                      chk_rdata_i,
  input  logic [15:0]               div_i,
  input  logic [NUM_UARTS-1:0][7:0] exp_byte_i,
  output int                        check_count_o,
  output int                        frame_count_o,
  output int                        reboot_count_o,
  output int                        error_count_o
);

  localparam int HOLD_CYCLES = 16;

  int bus_errors;
  int frame_errors;
  int reset_errors;
  int latency;

  assign error_count_o = bus_errors + frame_errors + reset_errors;

  ////////////////////////////////////////////////////////////
  // bus replies
  ////////////////////////////////////////////////////////////
  // cycles with valid high before the ready pulse
  always @(posedge clk) begin
    if (!resetn) begin
      latency = 0;
    end else if (mem_ready_i) begin
      check_count_o = check_count_o + 1;
      if (latency != 1) begin
        $display("[ERROR] %0t: step %0d ready after %0d cycles, expected 1",
                 $time, test_id_i, latency);
        bus_errors++;
      end else if (access_fault_i !== exp_fault_i) begin
        $display("[ERROR] %0t: step %0d fault %b, expected %b",
                 $time, test_id_i, access_fault_i, exp_fault_i);
        bus_errors++;
      end else if (chk_rdata_i && (mem_rdata_i !== exp_rdata_i)) begin
        $display("[ERROR] %0t: step %0d read %h, expected %h",
                 $time, test_id_i, mem_rdata_i, exp_rdata_i);
        bus_errors++;
      end else begin
        $display("step %0d ok", test_id_i);
      end
      latency = 0;
    end else begin
      latency = mem_valid_i ? latency + 1 : 0;
    end
  end

  // reboot pulses only, the board reset is not counted
  always begin : reset_watch
    int low;
    @(negedge core_resetn_i);
    if (resetn === 1'b1) begin
      low = 0;
      @(negedge clk);
      while (core_resetn_i === 1'b0 && low <= 4 * HOLD_CYCLES) begin
        low++;
        @(negedge clk);
      end
      reboot_count_o = reboot_count_o + 1;
      if (low != HOLD_CYCLES) begin
        $display("[ERROR] %0t: core reset low for %0d cycles, expected %0d",
                 $time, low, HOLD_CYCLES);
        reset_errors++;
      end else begin
        $display("core reset pulse of %0d cycles ok", low);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // serial frames, sampled mid bit on the falling clock
  ////////////////////////////////////////////////////////////
  task automatic watch_line(input int u);
    logic [7:0] got;
    logic       prev;
    logic       framed;
    int         d;
    prev = 1'b1;
    forever begin
      @(negedge clk);
      if (resetn === 1'b1 && prev === 1'b1 && uart_tx_i[u] === 1'b0) begin
        d = (div_i == 16'd0) ? 1 : int'(div_i);
        repeat (d / 2) @(negedge clk);
        framed = (uart_tx_i[u] === 1'b0);
        for (int b = 0; b < 8; b++) begin
          repeat (d) @(negedge clk);
          got[b] = uart_tx_i[u];
        end
        repeat (d) @(negedge clk);
        framed = framed && (uart_tx_i[u] === 1'b1);
        frame_count_o = frame_count_o + 1;
        if (!framed || got !== exp_byte_i[u]) begin
          $display("[ERROR] %0t: uart %0d sent %02h framed %b, expected %02h",
                   $time, u, got, framed, exp_byte_i[u]);
          frame_errors++;
        end else begin
          $display("uart %0d frame %02h ok", u, got);
        end
      end
      prev = uart_tx_i[u];
    end
  endtask

  initial begin
    for (int u = 0; u < NUM_UARTS; u++) begin
      fork
        automatic int k = u;
        watch_line(k);
      join_none
    end
  end

endmodule

// ==== source/soc_periph.sv ====
// peripheral subsystem top, bus decode with system registers, boot ram and uarts
`timescale 1ns/100ps

module soc_periph #(
  parameter int NUM_UARTS = 2
) (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   mem_valid_i,
  input  soc_pkg::addr_t         mem_addr_i,
  input  soc_pkg::word_t         mem_wdata_i,
  input  soc_pkg::wstrb_t        mem_wstrb_i,
  output soc_pkg::word_t         mem_rdata_o,
  output logic                   mem_ready_o,
  output logic                   access_fault_o,
  output logic                   core_resetn_o,
  output logic [NUM_UARTS-1:0]   uart_tx_o
);

  // target selects and replies
  logic                ram_sel;
  logic                ram_ready;
  soc_pkg::word_t      ram_rdata;
  logic                sys_sel;
  logic                sys_ready;
  soc_pkg::word_t      sys_rdata;
  logic [NUM_UARTS-1:0] uart_sel;
  logic [NUM_UARTS-1:0] uart_ready;
  soc_pkg::word_t      uart_rdata [NUM_UARTS];
  logic                lsr_access;
  soc_pkg::div_t       div;

  // controller to transmitter
  logic [NUM_UARTS-1:0] tx_start;
  logic [7:0]          tx_byte [NUM_UARTS];
  logic [NUM_UARTS-1:0] tx_busy;

  bus_decode #(
    .NUM_UARTS(NUM_UARTS)
  ) bus_decode_i (
    .clk           (clk),
    .resetn        (core_resetn_o),
    .mem_valid_i   (mem_valid_i),
    .mem_addr_i    (mem_addr_i),
    .mem_wstrb_i   (mem_wstrb_i),
    .ram_sel_o     (ram_sel),
    .sys_sel_o     (sys_sel),
    .uart_sel_o    (uart_sel),
    .lsr_access_o  (lsr_access),
    .ram_ready_i   (ram_ready),
    .ram_rdata_i   (ram_rdata),
    .sys_ready_i   (sys_ready),
    .sys_rdata_i   (sys_rdata),
    .uart_ready_i  (uart_ready),
    .uart_rdata_i  (uart_rdata),
    .mem_rdata_o   (mem_rdata_o),
    .mem_ready_o   (mem_ready_o),
    .access_fault_o(access_fault_o)
  );

  sys_regs sys_regs_i (
    .clk          (clk),
    .resetn       (resetn),
    .sys_sel_i    (sys_sel),
    .addr_i       (mem_addr_i),
    .wdata_i      (mem_wdata_i),
    .wstrb_i      (mem_wstrb_i),
    .rdata_o      (sys_rdata),
    .ready_o      (sys_ready),
    .div_o        (div),
    .core_resetn_o(core_resetn_o)
  );

  boot_ram boot_ram_i (
    .clk      (clk),
    .resetn   (core_resetn_o),
    .ram_sel_i(ram_sel),
    .addr_i   (mem_addr_i),
    .wdata_i  (mem_wdata_i),
    .wstrb_i  (mem_wstrb_i),
    .rdata_o  (ram_rdata),
    .ready_o  (ram_ready)
  );

  ////////////////////////////////////////////////////////////
  // one controller and transmitter per uart
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < NUM_UARTS; i++) begin : g_uart
    uart_ctrl uart_ctrl_i (
      .clk         (clk),
      .resetn      (core_resetn_o),
      .uart_sel_i  (uart_sel[i]),
      .lsr_access_i(lsr_access),
      .wdata_i     (mem_wdata_i),
      .wstrb_i     (mem_wstrb_i),
      .busy_i      (tx_busy[i]),
      .tx_start_o  (tx_start[i]),
      .tx_byte_o   (tx_byte[i]),
      .rdata_o     (uart_rdata[i]),
      .ready_o     (uart_ready[i])
    );

    uart_tx uart_tx_i (
      .clk    (clk),
      .resetn (core_resetn_o),
      .start_i(tx_start[i]),
      .byte_i (tx_byte[i]),
      .div_i  (div),
      .busy_o (tx_busy[i]),
      .tx_o   (uart_tx_o[i])
    );
  end

endmodule

// ==== uart/uart_tx.sv ====
// uart transmitter, start bit, 8 data bits lsb first and stop bit
`timescale 1ns/100ps

module uart_tx (
  input  logic          clk,
  input  logic          resetn,
  input  logic          start_i,
  input  logic [7:0]    byte_i,
  input  soc_pkg::div_t div_i,
  output logic          busy_o,
  output logic          tx_o
);

  soc_pkg::tx_state_t state_q;
  soc_pkg::div_t      cnt_q;
  logic [2:0]         bit_q;
  logic [7:0]         shift_q;
  logic               bit_end;

  // last clock of the current bit, divisor 0 acts like 1
  assign bit_end = ({1'b0, cnt_q} + 17'd1) >= {1'b0, div_i};

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q <= soc_pkg::TX_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      shift_q <= '0;
      tx_o    <= 1'b1;
    end else begin
      cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
      case (state_q)
        soc_pkg::TX_IDLE: begin
          cnt_q <= '0;
          tx_o  <= 1'b1;
          if (start_i) begin
            shift_q <= byte_i;
            tx_o    <= 1'b0;
            state_q <= soc_pkg::TX_START;
          end
        end
        soc_pkg::TX_START: begin
          if (bit_end) begin
            bit_q   <= '0;
            tx_o    <= shift_q[0];
            state_q <= soc_pkg::TX_DATA;
          end
        end
        soc_pkg::TX_DATA: begin
          if (bit_end) begin
            if (bit_q == 3'd7) begin
              tx_o    <= 1'b1;
              state_q <= soc_pkg::TX_STOP;
            end else begin
              shift_q <= shift_q >> 1;
              tx_o    <= shift_q[1];
              bit_q   <= bit_q + 1'b1;
            end
          end
        end
        soc_pkg::TX_STOP: begin
          if (bit_end) state_q <= soc_pkg::TX_IDLE;
        end
        default: state_q <= soc_pkg::TX_IDLE;
      endcase
    end
  end

  // high through the end of the stop bit
  assign busy_o = (state_q != soc_pkg::TX_IDLE);

endmodule

// ==== uart/uart_ctrl.sv ====
// uart register block, transmit register and line status register
`timescale 1ns/100ps

module uart_ctrl (
  input  logic            clk,
  input  logic            resetn,
  input  logic            uart_sel_i,
  input  logic            lsr_access_i,
  input  soc_pkg::word_t  wdata_i,
  input  soc_pkg::wstrb_t wstrb_i,
  input  logic            busy_i,
  output logic            tx_start_o,
  output logic [7:0]      tx_byte_o,
  output soc_pkg::word_t  rdata_o,
  output logic            ready_o
);

  logic tx_write;
  logic tx_idle;

  assign tx_write = uart_sel_i && !lsr_access_i && (|wstrb_i);
  // a start still in flight counts as busy
  assign tx_idle  = !busy_i && !tx_start_o;

  ////////////////////////////////////////////////////////////
  // transmit register
  ////////////////////////////////////////////////////////////
  // byte dropped when the transmitter is busy
  always_ff @(posedge clk) begin
    if (!resetn) tx_start_o <= 1'b0;
    else tx_start_o <= tx_write && tx_idle;
  end

  always_ff @(posedge clk) begin
    if (tx_write) tx_byte_o <= wdata_i[7:0];
  end

  ////////////////////////////////////////////////////////////
  // reply
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!resetn) ready_o <= 1'b0;
    else ready_o <= uart_sel_i;
  end

  // line status reports transmit state only
  always_ff @(posedge clk) begin
    if (uart_sel_i) begin
      rdata_o <= (lsr_access_i && tx_idle) ? soc_pkg::LSR_TX_EMPTY_BITS : '0;
    end
  end

  assert property (@(posedge clk) disable iff (!resetn)
    tx_start_o |-> !busy_i)
    else $error("uart_ctrl: start issued to a busy transmitter");

endmodule

// ==== source/boot_ram.sv ====
// boot ram, word organised with byte write enables and one cycle reply
`timescale 1ns/100ps

module boot_ram (
  input  logic            clk,
  input  logic            resetn,
  input  logic            ram_sel_i,
  input  soc_pkg::addr_t  addr_i,
  input  soc_pkg::word_t  wdata_i,
  input  soc_pkg::wstrb_t wstrb_i,
  output soc_pkg::word_t  rdata_o,
  output logic            ready_o
);

  localparam int AW = $clog2(soc_pkg::BRAM_WORDS);

  soc_pkg::word_t mem [soc_pkg::BRAM_WORDS];
  logic [AW-1:0]  word_addr;

  // byte address to word index
  assign word_addr = addr_i[2 +: AW];

  always_ff @(posedge clk) begin
    if (ram_sel_i) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_i[b]) mem[word_addr][8*b +: 8] <= wdata_i[8*b +: 8];
      end
      rdata_o <= mem[word_addr];
    end
  end

  // reply comes with the registered word
  always_ff @(posedge clk) begin
    if (!resetn) ready_o <= 1'b0;
    else ready_o <= ram_sel_i;
  end

endmodule

// ==== source/sys_regs.sv ====
// system registers with uart divider, clock and memory size, plus reboot reset
`timescale 1ns/100ps

module sys_regs (
  input  logic            clk,
  input  logic            resetn,
  input  logic            sys_sel_i,
  input  soc_pkg::addr_t  addr_i,
  input  soc_pkg::word_t  wdata_i,
  input  soc_pkg::wstrb_t wstrb_i,
  output soc_pkg::word_t  rdata_o,
  output logic            ready_o,
  output soc_pkg::div_t   div_o,
  output logic            core_resetn_o
);

  localparam int HOLD_W = $clog2(soc_pkg::RESET_HOLD + 1);

  logic              wr;
  logic              reboot_hit;
  logic              reboot_q;
  logic [HOLD_W-1:0] hold_q;
  soc_pkg::word_t    div_q;

  assign wr = |wstrb_i;
  assign reboot_hit = sys_sel_i && wr && (addr_i == soc_pkg::REBOOT_ADDR) &&
                      (wdata_i[15:0] == soc_pkg::REBOOT_DATA);

  ////////////////////////////////////////////////////////////
  // core reset generator, clocked by the board reset
  ////////////////////////////////////////////////////////////
  // reboot_q lines up with the ready pulse, so core reset falls one cycle later
  always_ff @(posedge clk) begin
    if (!resetn) begin
      reboot_q      <= 1'b0;
      hold_q        <= '0;
      core_resetn_o <= 1'b0;
    end else begin
      reboot_q <= reboot_hit;
      if (reboot_q) begin
        hold_q        <= HOLD_W'(soc_pkg::RESET_HOLD - 1);
        core_resetn_o <= 1'b0;
      end else if (hold_q != '0) begin
        hold_q <= hold_q - 1'b1;
      end else begin
        core_resetn_o <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // register access
  ////////////////////////////////////////////////////////////
  // divider with byte strobes
  always_ff @(posedge clk) begin
    if (!core_resetn_o) begin
      div_q <= '0;
    end else if (sys_sel_i && wr && (addr_i == soc_pkg::DIV_ADDR)) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_i[b]) div_q[8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!core_resetn_o) ready_o <= 1'b0;
    else ready_o <= sys_sel_i;
  end

  always_ff @(posedge clk) begin
    if (sys_sel_i) begin
      case (addr_i)
        soc_pkg::DIV_ADDR:      rdata_o <= div_q;
        soc_pkg::CPU_FREQ_ADDR: rdata_o <= soc_pkg::SYSTEM_CLK;
        soc_pkg::MEM_SIZE_ADDR: rdata_o <= soc_pkg::MEM_SIZE;
        default:                rdata_o <= '0;
      endcase
    end
  end

  // low half feeds the uart bit timers
  assign div_o = div_q[15:0];

  assert property (@(posedge clk) disable iff (!resetn)
    $fell(core_resetn_o) |-> !core_resetn_o [*soc_pkg::RESET_HOLD] ##1 core_resetn_o)
    else $error("sys_regs: core reset pulse has wrong length");

endmodule

// ==== source/bus_decode.sv ====
// memory bus decoder, target selects, unclaimed and fault replies, reply merge
`timescale 1ns/100ps

module bus_decode #(
  parameter int NUM_UARTS = 2
) (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   mem_valid_i,
  input  soc_pkg::addr_t         mem_addr_i,
  input  soc_pkg::wstrb_t        mem_wstrb_i,
  output logic                   ram_sel_o,
  output logic                   sys_sel_o,
  output logic [NUM_UARTS-1:0]   uart_sel_o,
  output logic                   lsr_access_o,
  input  logic                   ram_ready_i,
  input  soc_pkg::word_t         ram_rdata_i,
  input  logic                   sys_ready_i,
  input  soc_pkg::word_t         sys_rdata_i,
  input  logic [NUM_UARTS-1:0]   uart_ready_i,
  input  soc_pkg::word_t         uart_rdata_i [NUM_UARTS],
  output soc_pkg::word_t         mem_rdata_o,
  output logic                   mem_ready_o,
  output logic                   access_fault_o
);

  logic                 wr;
  logic                 rd;
  logic                 is_ram;
  logic                 is_io;
  logic                 is_sys;
  logic [NUM_UARTS-1:0] tx_hit;
  logic [NUM_UARTS-1:0] lsr_hit;
  logic                 unclaimed;
  logic                 fault;
  logic                 zero_ready_q;
  logic                 fault_ready_q;

  assign wr = |mem_wstrb_i;
  assign rd = ~wr;

  ////////////////////////////////////////////////////////////
  // region decode
  ////////////////////////////////////////////////////////////
  assign is_ram = mem_addr_i < soc_pkg::addr_t'(soc_pkg::BRAM_WORDS * 4);
  assign is_io  = (mem_addr_i >= soc_pkg::IO_BASE) && (mem_addr_i <= soc_pkg::IO_LIMIT);

  // constants are read only, reboot is write only
  assign is_sys = (mem_addr_i == soc_pkg::DIV_ADDR) ||
                  (rd && (mem_addr_i == soc_pkg::CPU_FREQ_ADDR)) ||
                  (rd && (mem_addr_i == soc_pkg::MEM_SIZE_ADDR)) ||
                  (wr && (mem_addr_i == soc_pkg::REBOOT_ADDR));

  for (genvar i = 0; i < NUM_UARTS; i++) begin : g_uart_match
    localparam soc_pkg::addr_t TX_ADDR = soc_pkg::UART_TX_BASE + soc_pkg::UART_STRIDE * i;

    assign tx_hit[i]  = wr && (mem_addr_i == TX_ADDR);
    assign lsr_hit[i] = rd && (mem_addr_i == TX_ADDR + soc_pkg::UART_LSR_OFFSET);
  end

  assign lsr_access_o = |lsr_hit;
  assign unclaimed    = is_io && !is_sys && !(|tx_hit) && !(|lsr_hit);
  assign fault        = !is_ram && !is_io;

  // one select per access, dropped while the target answers
  assign ram_sel_o  = mem_valid_i && is_ram && !ram_ready_i;
  assign sys_sel_o  = mem_valid_i && is_sys && !sys_ready_i;
  assign uart_sel_o = {NUM_UARTS{mem_valid_i}} & (tx_hit | lsr_hit) & ~uart_ready_i;

  // replies the decoder gives itself
  always_ff @(posedge clk) begin
    if (!resetn) begin
      zero_ready_q  <= 1'b0;
      fault_ready_q <= 1'b0;
    end else begin
      zero_ready_q  <= mem_valid_i && unclaimed && !zero_ready_q;
      fault_ready_q <= mem_valid_i && fault && !fault_ready_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // reply merge
  ////////////////////////////////////////////////////////////
  assign mem_ready_o    = ram_ready_i || sys_ready_i || (|uart_ready_i) ||
                          zero_ready_q || fault_ready_q;
  assign access_fault_o = fault_ready_q;

  // unclaimed and faulty accesses read as zero
  always_comb begin
    mem_rdata_o = (ram_ready_i ? ram_rdata_i : '0) | (sys_ready_i ? sys_rdata_i : '0);
    for (int k = 0; k < NUM_UARTS; k++) begin
      mem_rdata_o = mem_rdata_o | (uart_ready_i[k] ? uart_rdata_i[k] : '0);
    end
  end

  // targets are decoded exclusively, so replies never overlap
  assert property (@(posedge clk) disable iff (!resetn)
    $onehot0({ram_ready_i, sys_ready_i, uart_ready_i, zero_ready_q, fault_ready_q}))
    else $error("bus_decode: more than one target ready");

endmodule

// ==== common/soc_pkg.sv ====
// soc peripheral package with address map, bus widths and shared types
package soc_pkg;

  ////////////////////////////////////////////////////////////
  // bus and register widths
  ////////////////////////////////////////////////////////////
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  // all zero on a read
  typedef logic [3:0]  wstrb_t;
  // clocks per serial bit
  typedef logic [15:0] div_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////
  localparam int BRAM_WORDS = 256;

  // io window, limit inclusive
  localparam addr_t IO_BASE  = 32'h1000_0000;
  localparam addr_t IO_LIMIT = 32'h1200_0000;

  // uart n sits at UART_TX_BASE + n * UART_STRIDE
  localparam addr_t UART_TX_BASE    = 32'h1000_0000;
  localparam addr_t UART_LSR_OFFSET = 32'h0000_0005;
  localparam addr_t UART_STRIDE     = 32'h0000_1000;

  localparam addr_t DIV_ADDR      = 32'h1000_0010;
  localparam addr_t CPU_FREQ_ADDR = 32'h1000_0014;
  localparam addr_t MEM_SIZE_ADDR = 32'h1000_0018;
  localparam addr_t REBOOT_ADDR   = 32'h1100_0000;

  ////////////////////////////////////////////////////////////
  // register contents
  ////////////////////////////////////////////////////////////
  localparam logic [15:0] REBOOT_DATA = 16'h7777;
  localparam word_t SYSTEM_CLK = 32'd250_000_000;
  localparam word_t MEM_SIZE   = 32'd1024;
  // core reset length in clocks
  localparam int RESET_HOLD = 16;
  // line status bits 13 and 14, set while the transmitter is idle
  localparam word_t LSR_TX_EMPTY_BITS = 32'h0000_6000;

endpackage
